//--- filelist.f
+incdir+logic
logic/cpu_pkg.sv
logic/alu.sv
logic/regfile.sv
logic/controller.sv
logic/pc.sv
logic/forward.sv
logic/regwalls.sv
logic/cpu.sv
bench/cpu_checker.sv
bench/cpu_tb.sv

//--- run.sh
#!/usr/bin/env bash
set -u
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module cpu_tb \
	-f filelist.f --Mdir obj_dir -o cpu_sim
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

./obj_dir/cpu_sim > sim.log 2>&1
sim_status=$?
cat sim.log

if grep -q "SOME TESTS FAILED" sim.log; then
	exit 1
fi
if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi
if ! grep -q "ALL TESTS PASSED" sim.log; then
	echo "simulation ended without a result"
	exit 1
fi
exit 0

//--- bench/cpu_tb.sv
`timescale 1ns/100ps
`default_nettype none
`include "cpu_consts.svh"

module cpu_tb;
	localparam int PROG_LEN = 60;
	localparam int SWEEP_BASE = 256;
	localparam int TIMEOUT_CYCLES = PROG_LEN * 8 + 200;

	logic clock;
	logic rst;
	logic do_system = 1'b0;
	logic IM_ready = 1'b0;
	logic DM_ready = 1'b0;
	logic alu_overflow;
	logic IM_enable;
	logic DM_read;
	logic DM_write;
	cpu_pkg::word_t IM_address;
	cpu_pkg::word_t IM_out;
	cpu_pkg::word_t DM_address;
	cpu_pkg::word_t DM_in;
	cpu_pkg::word_t DM_out;

	cpu_pkg::word_t imem [256];
	cpu_pkg::word_t dmem [128];
	cpu_pkg::word_t model_mem [128];
	cpu_pkg::word_t model_regs [`CPU_NUM_REGS];
	cpu_pkg::word_t exp_addr [$];
	cpu_pkg::word_t exp_data [$];

	integer seed = 85413;
	int loop_idx;
	int exp_ovf;
	int ovf_seen = 0;
	int stores_seen = 0;
	int cycles = 0;

	assign IM_out = imem[IM_address[9:2]];
	// read data only while the core asks for it
	assign DM_out = DM_read ? dmem[DM_address[8:2]] : '0;

	cpu u_cpu (
		.clock(clock),
		.rst(rst),
		.do_system(do_system),
		.alu_overflow(alu_overflow),
		.IM_enable(IM_enable),
		.IM_address(IM_address),
		.IM_out(IM_out),
		.IM_ready(IM_ready),
		.DM_read(DM_read),
		.DM_write(DM_write),
		.DM_address(DM_address),
		.DM_in(DM_in),
		.DM_out(DM_out),
		.DM_ready(DM_ready)
	);

	bind cpu cpu_checker u_checker (
		.clock(clock),
		.rst(rst),
		.IM_enable(IM_enable),
		.DM_read(DM_read),
		.DM_write(DM_write)
	);

	task automatic stop_with_failure(input string msg);
		$display("%s", msg);
		$display("SOME TESTS FAILED");
		$fatal(1);
	endtask

	function automatic int rand_int(input int n);
		return int'({$random(seed)} % n);
	endfunction

	function automatic cpu_pkg::reg_addr_t rand_reg();
		return cpu_pkg::reg_addr_t'(1 + rand_int(8));
	endfunction

	function automatic cpu_pkg::word_t mem_fill(input int index);
		return cpu_pkg::word_t'(index) * 32'h9E37_79B9 ^ 32'hC3A5_0F1E;
	endfunction

	// true when the exact result leaves the signed 32-bit range
	function automatic logic out_of_range(input longint value);
		return value > 64'sd2147483647 || value < -64'sd2147483648;
	endfunction

	function automatic cpu_pkg::word_t encode(input cpu_pkg::opcode_e op,
		input cpu_pkg::reg_addr_t rt, input cpu_pkg::reg_addr_t ra, input logic [15:0] low);
		return {op, rt, ra, low};
	endfunction

	function automatic cpu_pkg::word_t encode_jump(input int target);
		cpu_pkg::word_t t;
		t = cpu_pkg::word_t'(target);
		return {cpu_pkg::OP_J, t[25:0]};
	endfunction

	task automatic build_program();
		int i;
		int kind;
		int off;
		cpu_pkg::reg_addr_t r1;
		cpu_pkg::reg_addr_t r2;
		cpu_pkg::reg_addr_t r3;
		logic [15:0] imm;
		logic [15:0] daddr;
		i = 0;
		while (i < PROG_LEN) begin
			kind = rand_int(16);
			off = 1 + rand_int(3);
			r1 = rand_reg();
			r2 = rand_reg();
			r3 = rand_reg();
			imm = 16'($random(seed));
			daddr = 16'(4 * rand_int(64));
			case (kind)
				0, 1, 2, 3, 4:
					imem[i] = encode(cpu_pkg::opcode_e'(6'(kind + 1)), r1, r2, {r3, 11'd0});
				5, 6: imem[i] = encode(cpu_pkg::OP_ADDI, r1, r2, imm);
				7: imem[i] = encode(cpu_pkg::OP_ORI, r1, r2, imm);
				8, 9: imem[i] = encode(cpu_pkg::OP_LW, r1, '0, daddr);
				10: imem[i] = encode(cpu_pkg::OP_SW, r1, '0, daddr);
				11: imem[i] = encode(cpu_pkg::OP_BEQ, r1, r2, 16'(off));
				12: imem[i] = encode(cpu_pkg::OP_BNE, r1, r2, 16'(off));
				13: imem[i] = encode_jump(i + 1 + off);
				14: begin
					// load then an immediate user
					if (i + 1 < PROG_LEN) begin
						imem[i] = encode(cpu_pkg::OP_LW, r1, '0, daddr);
						i++;
						imem[i] = encode(cpu_pkg::OP_ADD, r2, r1, {r3, 11'd0});
					end
				end
				default: imem[i] = encode(cpu_pkg::OP_ADD, r1, r1, {r2, 11'd0});
			endcase
			i++;
		end
		for (int r = 1; r < 32; r++)
			imem[PROG_LEN + r - 1] = encode(cpu_pkg::OP_SW, cpu_pkg::reg_addr_t'(r), '0,
				16'(SWEEP_BASE + 4 * (r - 1)));
		loop_idx = PROG_LEN + 31;
		imem[loop_idx] = encode_jump(loop_idx);
	endtask

	task automatic write_reg(input cpu_pkg::reg_addr_t rt, input cpu_pkg::word_t value);
		if (rt != '0)
			model_regs[rt] = value;
	endtask

	// sequential ISA model, program order
	task automatic run_model();
		int idx;
		int steps;
		cpu_pkg::word_t instr;
		cpu_pkg::word_t a;
		cpu_pkg::word_t b;
		cpu_pkg::word_t res;
		cpu_pkg::word_t simm;
		cpu_pkg::opcode_e op;
		cpu_pkg::reg_addr_t rt;
		logic [15:0] low;
		idx = int'(`CPU_RESET_PC / 4);
		steps = 0;
		while (idx != loop_idx && steps < 1000) begin
			instr = imem[idx];
			op = cpu_pkg::opcode_e'(instr[`CPU_OP_MSB:`CPU_OP_LSB]);
			rt = instr[`CPU_RT];
			low = instr[`CPU_IMM16];
			simm = {{16{low[15]}}, low};
			a = model_regs[instr[`CPU_RA]];
			b = model_regs[instr[`CPU_RB]];
			idx++;
			steps++;
			case (op)
				cpu_pkg::OP_ADD: begin
					res = a + b;
					if (out_of_range(longint'($signed(a)) + longint'($signed(b))))
						exp_ovf++;
					write_reg(rt, res);
				end
				cpu_pkg::OP_SUB: begin
					res = a - b;
					if (out_of_range(longint'($signed(a)) - longint'($signed(b))))
						exp_ovf++;
					write_reg(rt, res);
				end
				cpu_pkg::OP_AND: write_reg(rt, a & b);
				cpu_pkg::OP_OR: write_reg(rt, a | b);
				cpu_pkg::OP_XOR: write_reg(rt, a ^ b);
				cpu_pkg::OP_ADDI: begin
					res = a + simm;
					if (out_of_range(longint'($signed(a)) + longint'($signed(simm))))
						exp_ovf++;
					write_reg(rt, res);
				end
				cpu_pkg::OP_ORI: write_reg(rt, a | {16'h0000, low});
				cpu_pkg::OP_LW: begin
					res = a + simm;
					write_reg(rt, model_mem[res[8:2]]);
				end
				cpu_pkg::OP_SW: begin
					res = a + simm;
					model_mem[res[8:2]] = model_regs[rt];
					exp_addr.push_back(res);
					exp_data.push_back(model_regs[rt]);
				end
				cpu_pkg::OP_BEQ: if (model_regs[rt] == a) idx = idx + int'($signed(simm));
				cpu_pkg::OP_BNE: if (model_regs[rt] != a) idx = idx + int'($signed(simm));
				cpu_pkg::OP_J: idx = int'(instr[`CPU_IMM26]);
				default: ;
			endcase
		end
		if (steps >= 1000)
			stop_with_failure("reference model never reached the final loop");
	endtask

	task automatic check_store(input cpu_pkg::word_t addr, input cpu_pkg::word_t data);
		if (stores_seen >= exp_addr.size())
			stop_with_failure("DUT performed a store that the model does not have");
		else if (addr !== exp_addr[stores_seen])
			stop_with_failure($sformatf("[FAIL] DM_address got %h exp %h",
				addr, exp_addr[stores_seen]));
		else if (data !== exp_data[stores_seen])
			stop_with_failure($sformatf("[FAIL] DM_in got %h exp %h",
				data, exp_data[stores_seen]));
		else
			stores_seen++;
	endtask

	task automatic check_overflow_count(input int got, input int expected);
		if (got != expected)
			stop_with_failure($sformatf("[FAIL] alu_overflow count got %h exp %h",
				got, expected));
	endtask

	initial begin
		clock = 1'b0;
		forever #50 clock = ~clock;
	end

	// random stalls from core enable and both bus sides
	always @(negedge clock) begin
		do_system = rand_int(8) != 0;
		IM_ready = rand_int(4) != 0;
		DM_ready = rand_int(4) != 0;
	end

	always @(posedge clock) begin
		if (rst) begin
			for (int i = 0; i < 128; i++)
				dmem[i] <= mem_fill(i);
		end else if (do_system && IM_ready && DM_ready) begin
			if (DM_write) begin
				check_store(DM_address, DM_in);
				dmem[DM_address[8:2]] <= DM_in;
			end
			if (alu_overflow)
				ovf_seen++;
		end
	end

	always @(posedge clock) begin
		cycles++;
		if (cycles >= TIMEOUT_CYCLES)
			stop_with_failure("timeout, the program did not finish in time");
	end

	initial begin
		rst = 1'b1;
		exp_ovf = 0;
		for (int i = 0; i < 256; i++)
			imem[i] = '0;
		for (int i = 0; i < 128; i++)
			model_mem[i] = mem_fill(i);
		for (int i = 0; i < `CPU_NUM_REGS; i++)
			model_regs[i] = '0;
		build_program();
		run_model();
		repeat (5) @(negedge clock);
		rst = 1'b0;
		while (stores_seen < exp_addr.size())
			@(posedge clock);
		// catch stray stores behind the last one
		repeat (20) @(posedge clock);
		check_overflow_count(ovf_seen, exp_ovf);
		$display("ALL TESTS PASSED");
		$finish;
	end
endmodule

`default_nettype wire

//--- bench/cpu_checker.sv
`timescale 1ns/100ps
`default_nettype none

module cpu_checker (
	input wire logic clock,
	input wire logic rst,
	input wire logic IM_enable,
	input wire logic DM_read,
	input wire logic DM_write
);
	// one data access kind at a time
	a_dm_exclusive: assert property (@(posedge clock) disable iff (rst)
		!(DM_read && DM_write))
		else $error("DM_read and DM_write are high together");

	// walls come out of reset empty
	a_dm_idle_after_reset: assert property (@(posedge clock)
		$fell(rst) |-> (!DM_read && !DM_write))
		else $error("data strobe high right after reset release");

	a_im_enable: assert property (@(posedge clock) disable iff (rst) IM_enable)
		else $error("IM_enable dropped outside reset");
endmodule

`default_nettype wire

//--- logic/cpu.sv
`timescale 1ns/100ps
`default_nettype none
`include "cpu_consts.svh"

module cpu (
	input wire logic clock,
	input wire logic rst,
	input wire logic do_system,
	output logic alu_overflow,

	output logic IM_enable,
	output cpu_pkg::word_t IM_address,
	input wire cpu_pkg::word_t IM_out,
	input wire logic IM_ready,

	output logic DM_read,
	output logic DM_write,
	output cpu_pkg::word_t DM_address,
	output cpu_pkg::word_t DM_in,
	input wire cpu_pkg::word_t DM_out,
	input wire logic DM_ready
);
	logic enable;

	// decode
	cpu_pkg::word_t reg1_instr;
	cpu_pkg::reg_addr_t ra_addr;
	cpu_pkg::reg_addr_t rb_addr;
	cpu_pkg::reg_addr_t rt_addr;
	cpu_pkg::alu_op_e alu_op;
	logic use_imm;
	cpu_pkg::word_t imm;
	logic dm_read;
	logic dm_write;
	logic reg_write;
	cpu_pkg::wb_sel_e wb_sel;
	cpu_pkg::reg_addr_t dest;
	cpu_pkg::word_t ra_data;
	cpu_pkg::word_t rb_data;
	cpu_pkg::word_t rt_data;
	cpu_pkg::word_t f_ra;
	cpu_pkg::word_t f_rb;
	cpu_pkg::word_t f_rt;
	logic hazard;
	cpu_pkg::word_t current_pc;
	logic flush_reg1;

	// later stages
	cpu_pkg::alu_op_e reg2_alu_op;
	cpu_pkg::word_t reg2_a;
	cpu_pkg::word_t reg2_b;
	cpu_pkg::word_t reg2_store_data;
	logic reg2_reg_write;
	cpu_pkg::wb_sel_e reg2_wb_sel;
	cpu_pkg::reg_addr_t reg2_dest;
	cpu_pkg::word_t alu_result;
	logic reg3_dm_read;
	logic reg3_dm_write;
	cpu_pkg::word_t reg3_alu_result;
	cpu_pkg::word_t reg3_store_data;
	logic reg3_reg_write;
	cpu_pkg::reg_addr_t reg3_dest;
	cpu_pkg::word_t reg3_wb_data;
	logic reg4_reg_write;
	cpu_pkg::reg_addr_t reg4_dest;
	cpu_pkg::word_t reg4_wb_data;

	// a low ready anywhere freezes every stage
	assign enable = do_system && IM_ready && DM_ready;

	assign ra_addr = reg1_instr[`CPU_RA];
	assign rb_addr = reg1_instr[`CPU_RB];
	assign rt_addr = reg1_instr[`CPU_RT];

	assign IM_enable  = 1'b1;
	assign IM_address = current_pc;
	assign DM_read    = reg3_dm_read;
	assign DM_write   = reg3_dm_write;
	assign DM_address = reg3_alu_result;
	assign DM_in      = reg3_store_data;

	alu u_alu (
		.op(reg2_alu_op),
		.a(reg2_a),
		.b(reg2_b),
		.result(alu_result),
		.overflow(alu_overflow)
	);

	regfile u_regfile (
		.clock(clock),
		.rst(rst),
		.enable(enable),
		.ra_addr(ra_addr),
		.rb_addr(rb_addr),
		.rt_addr(rt_addr),
		.wr_addr(reg4_dest),
		.wr_en(reg4_reg_write),
		.wr_data(reg4_wb_data),
		.ra_data(ra_data),
		.rb_data(rb_data),
		.rt_data(rt_data)
	);

	controller u_controller (
		.instr(reg1_instr),
		.alu_op(alu_op),
		.use_imm(use_imm),
		.imm(imm),
		.dm_read(dm_read),
		.dm_write(dm_write),
		.reg_write(reg_write),
		.wb_sel(wb_sel),
		.dest(dest)
	);

	pc u_pc (
		.clock(clock),
		.rst(rst),
		.enable(enable),
		.hazard(hazard),
		.instr(reg1_instr),
		.f_ra(f_ra),
		.f_rt(f_rt),
		.current_pc(current_pc),
		.flush_reg1(flush_reg1)
	);

	forward u_forward (
		.ra_addr(ra_addr),
		.rb_addr(rb_addr),
		.rt_addr(rt_addr),
		.ra_data(ra_data),
		.rb_data(rb_data),
		.rt_data(rt_data),
		.reg2_reg_write(reg2_reg_write),
		.reg2_wb_sel(reg2_wb_sel),
		.reg2_dest(reg2_dest),
		.alu_result(alu_result),
		.reg3_reg_write(reg3_reg_write),
		.reg3_dest(reg3_dest),
		.reg3_wb_data(reg3_wb_data),
		.reg4_reg_write(reg4_reg_write),
		.reg4_dest(reg4_dest),
		.reg4_wb_data(reg4_wb_data),
		.f_ra(f_ra),
		.f_rb(f_rb),
		.f_rt(f_rt),
		.hazard(hazard)
	);

	regwalls u_regwalls (
		.clock(clock),
		.rst(rst),
		.enable(enable),
		.flush_reg1(flush_reg1),
		.hazard(hazard),
		.in_instr(IM_out),
		.in_alu_op(alu_op),
		.in_use_imm(use_imm),
		.in_imm(imm),
		.in_dm_read(dm_read),
		.in_dm_write(dm_write),
		.in_reg_write(reg_write),
		.in_wb_sel(wb_sel),
		.in_dest(dest),
		.in_ra_val(f_ra),
		.in_rb_val(f_rb),
		.in_rt_val(f_rt),
		.in_alu_result(alu_result),
		.in_dm_out(DM_out),
		.reg1_instr(reg1_instr),
		.reg2_alu_op(reg2_alu_op),
		.reg2_a(reg2_a),
		.reg2_b(reg2_b),
		.reg2_store_data(reg2_store_data),
		.reg2_reg_write(reg2_reg_write),
		.reg2_wb_sel(reg2_wb_sel),
		.reg2_dest(reg2_dest),
		.reg3_dm_read(reg3_dm_read),
		.reg3_dm_write(reg3_dm_write),
		.reg3_alu_result(reg3_alu_result),
		.reg3_store_data(reg3_store_data),
		.reg3_reg_write(reg3_reg_write),
		.reg3_dest(reg3_dest),
		.reg3_wb_data(reg3_wb_data),
		.reg4_reg_write(reg4_reg_write),
		.reg4_dest(reg4_dest),
		.reg4_wb_data(reg4_wb_data)
	);
endmodule

`default_nettype wire

//--- logic/regwalls.sv
`timescale 1ns/100ps
`default_nettype none

module regwalls (
	input wire logic clock,
	input wire logic rst,
	input wire logic enable,
	input wire logic flush_reg1,
	input wire logic hazard,

	input wire cpu_pkg::word_t in_instr,
	input wire cpu_pkg::alu_op_e in_alu_op,
	input wire logic in_use_imm,
	input wire cpu_pkg::word_t in_imm,
	input wire logic in_dm_read,
	input wire logic in_dm_write,
	input wire logic in_reg_write,
	input wire cpu_pkg::wb_sel_e in_wb_sel,
	input wire cpu_pkg::reg_addr_t in_dest,
	input wire cpu_pkg::word_t in_ra_val,
	input wire cpu_pkg::word_t in_rb_val,
	input wire cpu_pkg::word_t in_rt_val,
	input wire cpu_pkg::word_t in_alu_result,
	input wire cpu_pkg::word_t in_dm_out,

	output cpu_pkg::word_t reg1_instr,
	output cpu_pkg::alu_op_e reg2_alu_op,
	output cpu_pkg::word_t reg2_a,
	output cpu_pkg::word_t reg2_b,
	output cpu_pkg::word_t reg2_store_data,
	output logic reg2_reg_write,
	output cpu_pkg::wb_sel_e reg2_wb_sel,
	output cpu_pkg::reg_addr_t reg2_dest,
	output logic reg3_dm_read,
	output logic reg3_dm_write,
	output cpu_pkg::word_t reg3_alu_result,
	output cpu_pkg::word_t reg3_store_data,
	output logic reg3_reg_write,
	output cpu_pkg::reg_addr_t reg3_dest,
	output cpu_pkg::word_t reg3_wb_data,
	output logic reg4_reg_write,
	output cpu_pkg::reg_addr_t reg4_dest,
	output cpu_pkg::word_t reg4_wb_data
);
	logic reg2_dm_read;
	logic reg2_dm_write;
	cpu_pkg::wb_sel_e reg3_wb_sel;

	// MEM stage result, also the MEM forward source
	assign reg3_wb_data = (reg3_wb_sel == cpu_pkg::WB_MEM) ? in_dm_out : reg3_alu_result;

	always_ff @(posedge clock) begin
		if (rst) begin
			reg1_instr     <= '0;
			reg2_alu_op    <= cpu_pkg::ALU_PASS_B;
			reg2_dm_read   <= 1'b0;
			reg2_dm_write  <= 1'b0;
			reg2_reg_write <= 1'b0;
			reg2_wb_sel    <= cpu_pkg::WB_ALU;
			reg2_dest      <= '0;
			reg3_dm_read   <= 1'b0;
			reg3_dm_write  <= 1'b0;
			reg3_reg_write <= 1'b0;
			reg3_wb_sel    <= cpu_pkg::WB_ALU;
			reg3_dest      <= '0;
			reg4_reg_write <= 1'b0;
			reg4_dest      <= '0;
		end else if (enable) begin
			if (flush_reg1)
				reg1_instr <= '0;
			else if (!hazard)
				reg1_instr <= in_instr;
			// bubble into EX while the load finishes
			reg2_alu_op    <= hazard ? cpu_pkg::ALU_PASS_B : in_alu_op;
			reg2_dm_read   <= !hazard && in_dm_read;
			reg2_dm_write  <= !hazard && in_dm_write;
			reg2_reg_write <= !hazard && in_reg_write;
			reg2_wb_sel    <= in_wb_sel;
			reg2_dest      <= in_dest;
			reg3_dm_read   <= reg2_dm_read;
			reg3_dm_write  <= reg2_dm_write;
			reg3_reg_write <= reg2_reg_write;
			reg3_wb_sel    <= reg2_wb_sel;
			reg3_dest      <= reg2_dest;
			reg4_reg_write <= reg3_reg_write;
			reg4_dest      <= reg3_dest;
		end
	end

	always_ff @(posedge clock) begin
		if (enable) begin
			reg2_a          <= in_ra_val;
			reg2_b          <= in_use_imm ? in_imm : in_rb_val;
			reg2_store_data <= in_rt_val;
			reg3_alu_result <= in_alu_result;
			reg3_store_data <= reg2_store_data;
			reg4_wb_data    <= reg3_wb_data;
		end
	end
endmodule

`default_nettype wire

//--- logic/forward.sv
`timescale 1ns/100ps
`default_nettype none

module forward (
	input wire cpu_pkg::reg_addr_t ra_addr,
	input wire cpu_pkg::reg_addr_t rb_addr,
	input wire cpu_pkg::reg_addr_t rt_addr,
	input wire cpu_pkg::word_t ra_data,
	input wire cpu_pkg::word_t rb_data,
	input wire cpu_pkg::word_t rt_data,

	input wire logic reg2_reg_write,
	input wire cpu_pkg::wb_sel_e reg2_wb_sel,
	input wire cpu_pkg::reg_addr_t reg2_dest,
	input wire cpu_pkg::word_t alu_result,

	input wire logic reg3_reg_write,
	input wire cpu_pkg::reg_addr_t reg3_dest,
	input wire cpu_pkg::word_t reg3_wb_data,

	input wire logic reg4_reg_write,
	input wire cpu_pkg::reg_addr_t reg4_dest,
	input wire cpu_pkg::word_t reg4_wb_data,

	output cpu_pkg::word_t f_ra,
	output cpu_pkg::word_t f_rb,
	output cpu_pkg::word_t f_rt,
	output logic hazard
);
	logic ex_alu;
	logic ex_load;

	assign ex_alu = reg2_reg_write && reg2_wb_sel == cpu_pkg::WB_ALU;
	assign ex_load = reg2_reg_write && reg2_wb_sel == cpu_pkg::WB_MEM && reg2_dest != '0;

	// youngest producer wins
	function automatic cpu_pkg::word_t pick(input cpu_pkg::reg_addr_t addr,
		input cpu_pkg::word_t rf_data);
		if (addr == '0)
			return rf_data;
		if (ex_alu && reg2_dest == addr)
			return alu_result;
		if (reg3_reg_write && reg3_dest == addr)
			return reg3_wb_data;
		if (reg4_reg_write && reg4_dest == addr)
			return reg4_wb_data;
		return rf_data;
	endfunction

	always_comb begin
		f_ra = pick(ra_addr, ra_data);
		f_rb = pick(rb_addr, rb_data);
		f_rt = pick(rt_addr, rt_data);
	end

	// load result not ready until MEM
	assign hazard = ex_load
		&& (reg2_dest == ra_addr || reg2_dest == rb_addr || reg2_dest == rt_addr);
endmodule

`default_nettype wire

//--- logic/pc.sv
`timescale 1ns/100ps
`default_nettype none
`include "cpu_consts.svh"

module pc (
	input wire logic clock,
	input wire logic rst,
	input wire logic enable,
	input wire logic hazard,
	input wire cpu_pkg::word_t instr,
	input wire cpu_pkg::word_t f_ra,
	input wire cpu_pkg::word_t f_rt,
	output cpu_pkg::word_t current_pc,
	output logic flush_reg1
);
	cpu_pkg::opcode_e op;
	cpu_pkg::word_t branch_pc;
	cpu_pkg::word_t br_target;
	cpu_pkg::word_t j_target;
	logic taken;
	logic jump;

	assign op = cpu_pkg::opcode_e'(instr[`CPU_OP_MSB:`CPU_OP_LSB]);

	// fetch has already moved one word past the branch in decode
	assign branch_pc = current_pc - 32'd4;
	assign br_target = branch_pc + 32'd4
		+ {{14{instr[15]}}, instr[`CPU_IMM16], 2'b00};
	assign j_target = {current_pc[31:28], instr[`CPU_IMM26], 2'b00};

	assign taken = !hazard && ((op == cpu_pkg::OP_BEQ && f_rt == f_ra)
		|| (op == cpu_pkg::OP_BNE && f_rt != f_ra));
	assign jump = !hazard && op == cpu_pkg::OP_J;
	assign flush_reg1 = taken || jump;

	always_ff @(posedge clock) begin
		if (rst)
			current_pc <= `CPU_RESET_PC;
		else if (enable) begin
			if (taken)
				current_pc <= br_target;
			else if (jump)
				current_pc <= j_target;
			else if (!hazard)
				current_pc <= current_pc + 32'd4;
		end
	end
endmodule

`default_nettype wire

//--- logic/controller.sv
`timescale 1ns/100ps
`default_nettype none
`include "cpu_consts.svh"

module controller (
	input wire cpu_pkg::word_t instr,
	output cpu_pkg::alu_op_e alu_op,
	output logic use_imm,
	output cpu_pkg::word_t imm,
	output logic dm_read,
	output logic dm_write,
	output logic reg_write,
	output cpu_pkg::wb_sel_e wb_sel,
	output cpu_pkg::reg_addr_t dest
);
	cpu_pkg::opcode_e op;
	logic [15:0] imm16;

	assign op = cpu_pkg::opcode_e'(instr[`CPU_OP_MSB:`CPU_OP_LSB]);
	assign imm16 = instr[`CPU_IMM16];
	assign dest = instr[`CPU_RT];

	always_comb begin
		alu_op    = cpu_pkg::ALU_PASS_B;
		use_imm   = 1'b0;
		imm       = {{16{imm16[15]}}, imm16};
		dm_read   = 1'b0;
		dm_write  = 1'b0;
		reg_write = 1'b0;
		wb_sel    = cpu_pkg::WB_ALU;
		case (op)
			cpu_pkg::OP_ADD: begin
				alu_op    = cpu_pkg::ALU_ADD;
				reg_write = 1'b1;
			end
			cpu_pkg::OP_SUB: begin
				alu_op    = cpu_pkg::ALU_SUB;
				reg_write = 1'b1;
			end
			cpu_pkg::OP_AND: begin
				alu_op    = cpu_pkg::ALU_AND;
				reg_write = 1'b1;
			end
			cpu_pkg::OP_OR: begin
				alu_op    = cpu_pkg::ALU_OR;
				reg_write = 1'b1;
			end
			cpu_pkg::OP_XOR: begin
				alu_op    = cpu_pkg::ALU_XOR;
				reg_write = 1'b1;
			end
			cpu_pkg::OP_ADDI: begin
				alu_op    = cpu_pkg::ALU_ADD;
				use_imm   = 1'b1;
				reg_write = 1'b1;
			end
			cpu_pkg::OP_ORI: begin
				alu_op    = cpu_pkg::ALU_OR;
				use_imm   = 1'b1;
				imm       = {16'h0000, imm16};
				reg_write = 1'b1;
			end
			// address is ra + imm for both memory ops
			cpu_pkg::OP_LW: begin
				alu_op    = cpu_pkg::ALU_ADD;
				use_imm   = 1'b1;
				dm_read   = 1'b1;
				reg_write = 1'b1;
				wb_sel    = cpu_pkg::WB_MEM;
			end
			cpu_pkg::OP_SW: begin
				alu_op    = cpu_pkg::ALU_ADD;
				use_imm   = 1'b1;
				dm_write  = 1'b1;
			end
			default: ;
		endcase
	end
endmodule

`default_nettype wire

//--- logic/regfile.sv
`timescale 1ns/100ps
`default_nettype none
`include "cpu_consts.svh"

module regfile (
	input wire logic clock,
	input wire logic rst,
	input wire logic enable,
	input wire cpu_pkg::reg_addr_t ra_addr,
	input wire cpu_pkg::reg_addr_t rb_addr,
	input wire cpu_pkg::reg_addr_t rt_addr,
	input wire cpu_pkg::reg_addr_t wr_addr,
	input wire logic wr_en,
	input wire cpu_pkg::word_t wr_data,
	output cpu_pkg::word_t ra_data,
	output cpu_pkg::word_t rb_data,
	output cpu_pkg::word_t rt_data
);
	cpu_pkg::word_t regs [`CPU_NUM_REGS];

	// r0 is never written, so it reads zero
	always_ff @(posedge clock) begin
		if (rst) begin
			for (int i = 0; i < `CPU_NUM_REGS; i++)
				regs[i] <= '0;
		end else if (enable && wr_en && wr_addr != '0) begin
			regs[wr_addr] <= wr_data;
		end
	end

	assign ra_data = regs[ra_addr];
	assign rb_data = regs[rb_addr];
	assign rt_data = regs[rt_addr];
endmodule

`default_nettype wire

//--- logic/alu.sv
`timescale 1ns/100ps
`default_nettype none

module alu (
	input wire cpu_pkg::alu_op_e op,
	input wire cpu_pkg::word_t a,
	input wire cpu_pkg::word_t b,
	output cpu_pkg::word_t result,
	output logic overflow
);
	localparam int MSB = $bits(cpu_pkg::word_t) - 1;

	always_comb begin
		case (op)
			cpu_pkg::ALU_ADD: result = a + b;
			cpu_pkg::ALU_SUB: result = a - b;
			cpu_pkg::ALU_AND: result = a & b;
			cpu_pkg::ALU_OR:  result = a | b;
			cpu_pkg::ALU_XOR: result = a ^ b;
			default:          result = b;
		endcase
	end

	// signed overflow, add and sub only
	always_comb begin
		overflow = 1'b0;
		if (op == cpu_pkg::ALU_ADD)
			overflow = (a[MSB] == b[MSB]) && (result[MSB] != a[MSB]);
		else if (op == cpu_pkg::ALU_SUB)
			overflow = (a[MSB] != b[MSB]) && (result[MSB] != a[MSB]);
	end
endmodule

`default_nettype wire

//--- logic/cpu_pkg.sv
`default_nettype none
`include "cpu_consts.svh"

package cpu_pkg;

	typedef logic [`CPU_WORD_W-1:0] word_t;
	typedef logic [`CPU_REG_AW-1:0] reg_addr_t;

	// unlisted codes decode as nop
	typedef enum logic [5:0] {
		OP_NOP  = 6'd0,
		OP_ADD  = 6'd1,
		OP_SUB  = 6'd2,
		OP_AND  = 6'd3,
		OP_OR   = 6'd4,
		OP_XOR  = 6'd5,
		OP_ADDI = 6'd6,
		OP_ORI  = 6'd7,
		OP_LW   = 6'd8,
		OP_SW   = 6'd9,
		OP_BEQ  = 6'd10,
		OP_BNE  = 6'd11,
		OP_J    = 6'd12
	} opcode_e;

	typedef enum logic [2:0] {ALU_PASS_B, ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR} alu_op_e;

	typedef enum logic {WB_ALU, WB_MEM} wb_sel_e;

endpackage

`default_nettype wire

//--- logic/cpu_consts.svh
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// datapath widths
`define CPU_WORD_W 32
`define CPU_REG_AW 5
`define CPU_NUM_REGS 32

`define CPU_RESET_PC 32'h0000_0000

// instruction fields
`define CPU_OP_MSB 31
`define CPU_OP_LSB 26
`define CPU_RT 25:21
`define CPU_RA 20:16
`define CPU_RB 15:11
`define CPU_IMM16 15:0
`define CPU_IMM26 25:0

`endif
